// ==== hw/tx_async_pkg.sv ====
// Bit layout of the slow image. Offsets must stay contiguous and
// end at SSR_WIDTH-1 because the slow path packs every bit.
`default_nettype none

package tx_async_pkg;

  localparam int SSR_WIDTH = 24;

  // Multi-bit field widths
  localparam int BOUNDARY_SEL_W = 5;
  localparam int BITSLIP_W      = 7;
  localparam int CNT_SEL_W      = 4;
  localparam int PHASE_SHIFTS_W = 3;

  // Field positions in the image
  localparam int BOUNDARY_SEL_LSB = 0;
  localparam int BITSLIP_LSB      = BOUNDARY_SEL_LSB + BOUNDARY_SEL_W;
  localparam int CNT_SEL_LSB      = BITSLIP_LSB + BITSLIP_W;
  localparam int PHASE_SHIFTS_LSB = CNT_SEL_LSB + CNT_SEL_W;

  // Single-bit controls and status
  localparam int POLINV_BIT       = PHASE_SHIFTS_LSB + PHASE_SHIFTS_W;
  localparam int LATENCY_ADJ_BIT  = POLINV_BIT + 1;
  localparam int DCD_CAL_DONE_BIT = LATENCY_ADJ_BIT + 1;
  localparam int DLL_LOCK_REQ_BIT = DCD_CAL_DONE_BIT + 1;
  localparam int TRANSFER_EN_BIT  = DLL_LOCK_REQ_BIT + 1;

  typedef logic [SSR_WIDTH-1:0]      ssr_data_t;
  typedef logic [BOUNDARY_SEL_W-1:0] boundary_sel_t;
  typedef logic [BITSLIP_W-1:0]      bitslip_t;
  typedef logic [CNT_SEL_W-1:0]      cnt_sel_t;
  typedef logic [PHASE_SHIFTS_W-1:0] phase_shifts_t;

endpackage

`default_nettype wire

// ==== hw/capture_pkg.sv ====
// Reset levels and default synchronizer depths of the capture cells.
// Depths below 2 are rejected by the cell at elaboration.
`default_nettype none

package capture_pkg;

  // Fast path sees the idle request, so it gets the deeper chain
  localparam int FSR_SYNC_STAGES_DEF = 4;
  localparam int SSR_SYNC_STAGES_DEF = 2;

  // Config fields come up as all ones
  localparam logic CFG_RESET_VAL = 1'b1;

  // Status and request bits come up deasserted
  localparam logic STATUS_RESET_VAL = 1'b0;

endpackage

`default_nettype wire

// ==== hw/async_capture.sv ====
// Input must stay stable longer than SYNC_STAGES clocks; every bit is
// synchronized on its own, so a changing vector can be caught half-updated.
`timescale 1ns/1ps
`default_nettype none

module async_capture #(
  parameter type      payload_t   = logic,
  parameter payload_t RESET_VAL   = '0,
  parameter int       SYNC_STAGES = 2
) (
  input  wire      tx_osc_clk,
  input  wire      rst,
  input  payload_t data_in,
  input  wire      unload,
  output payload_t sync_out,
  output payload_t data_out
);

  payload_t sync_q [SYNC_STAGES];
  payload_t data_q;

  if (SYNC_STAGES < 2) begin : g_bad_depth
    $error("async_capture needs SYNC_STAGES of 2 or more");
  end

  // Synchronizer chain of one flop per stage
  always_ff @(posedge tx_osc_clk) begin
    if (rst) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= RESET_VAL;
      end
    end else begin
      sync_q[0] <= data_in;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Snapshot taken on the load strobe only
  always_ff @(posedge tx_osc_clk) begin
    if (rst) begin
      data_q <= RESET_VAL;
    end else if (unload) begin
      data_q <= sync_q[SYNC_STAGES-1];
    end
  end

  assign sync_out = sync_q[SYNC_STAGES-1];
  assign data_out = data_q;

  // Snapshot holds unless loaded or reset
  a_hold_without_unload : assert property (
    @(posedge tx_osc_clk) (!unload && !rst) |=> $stable(data_out)
  ) else $error("async_capture: data_out changed without unload");

endmodule

`default_nettype wire

// ==== hw/fast_sr_capture.sv ====
// r_txelecidle_rst_val is a static level; changing it after reset
// switches fsr_data between two independently loaded registers.
`timescale 1ns/1ps
`default_nettype none

module fast_sr_capture #(
  parameter int SYNC_STAGES = capture_pkg::FSR_SYNC_STAGES_DEF
) (
  input  wire  tx_osc_clk,
  input  wire  rst,
  input  wire  pld_txelecidle,
  input  wire  fsr_load,
  input  wire  r_txelecidle_rst_val,
  output logic fsr_data
);

  logic idle_rst1;
  logic idle_rst0;
  logic load_seen_q;

  // Same input and load, opposite reset levels
  async_capture #(
    .payload_t   (logic),
    .RESET_VAL   (1'b1),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_idle_rst1 (
    .tx_osc_clk (tx_osc_clk),
    .rst        (rst),
    .data_in    (pld_txelecidle),
    .unload     (fsr_load),
    .sync_out   (),
    .data_out   (idle_rst1)
  );

  async_capture #(
    .payload_t   (logic),
    .RESET_VAL   (1'b0),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_idle_rst0 (
    .tx_osc_clk (tx_osc_clk),
    .rst        (rst),
    .data_in    (pld_txelecidle),
    .unload     (fsr_load),
    .sync_out   (),
    .data_out   (idle_rst0)
  );

  assign fsr_data = r_txelecidle_rst_val ? idle_rst1 : idle_rst0;

  // Tracks whether any load happened since reset
  always_ff @(posedge tx_osc_clk) begin
    if (rst) begin
      load_seen_q <= 1'b0;
    end else if (fsr_load) begin
      load_seen_q <= 1'b1;
    end
  end

  a_reset_level : assert property (
    @(posedge tx_osc_clk) (!rst && !load_seen_q) |-> (fsr_data == r_txelecidle_rst_val)
  ) else $error("fast_sr_capture: fsr_data left its reset level before a load");

endmodule

`default_nettype wire

// ==== hw/slow_sr_capture.sv ====
// Bypass levels are static; a bypassed field shows the synchronizer
// output and ignores ssr_load.
`timescale 1ns/1ps
`default_nettype none

module slow_sr_capture #(
  parameter int SYNC_STAGES = capture_pkg::SSR_SYNC_STAGES_DEF
) (
  input  wire                        tx_osc_clk,
  input  wire                        rst,
  input  wire tx_async_pkg::boundary_sel_t pld_8g_tx_boundary_sel,
  input  wire tx_async_pkg::bitslip_t      pld_10g_tx_bitslip,
  input  wire tx_async_pkg::cnt_sel_t      pld_pma_fpll_cnt_sel,
  input  wire tx_async_pkg::phase_shifts_t pld_pma_fpll_num_phase_shifts,
  input  wire                        pld_polinv_tx,
  input  wire                        pld_tx_fifo_latency_adj_en,
  input  wire                        tx_dcd_cal_done,
  input  wire                        pld_tx_dll_lock_req,
  input  wire                        tx_transfer_en,
  input  wire                        ssr_load,
  input  wire                        r_boundary_sel_bypass,
  input  wire                        r_bitslip_bypass,
  input  wire                        r_cnt_sel_bypass,
  input  wire                        r_phase_shifts_bypass,
  output tx_async_pkg::ssr_data_t    ssr_data
);

  import tx_async_pkg::*;
  import capture_pkg::*;

  boundary_sel_t boundary_sel_sync, boundary_sel_q;
  bitslip_t      bitslip_sync, bitslip_q;
  cnt_sel_t      cnt_sel_sync, cnt_sel_q;
  phase_shifts_t phase_shifts_sync, phase_shifts_q;

  // Fields that can be polled
  async_capture #(
    .payload_t   (boundary_sel_t),
    .RESET_VAL   (boundary_sel_t'({BOUNDARY_SEL_W{CFG_RESET_VAL}})),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_boundary_sel (
    .tx_osc_clk (tx_osc_clk),
    .rst        (rst),
    .data_in    (pld_8g_tx_boundary_sel),
    .unload     (ssr_load),
    .sync_out   (boundary_sel_sync),
    .data_out   (boundary_sel_q)
  );

  async_capture #(
    .payload_t   (bitslip_t),
    .RESET_VAL   (bitslip_t'({BITSLIP_W{CFG_RESET_VAL}})),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_bitslip (
    .tx_osc_clk (tx_osc_clk),
    .rst        (rst),
    .data_in    (pld_10g_tx_bitslip),
    .unload     (ssr_load),
    .sync_out   (bitslip_sync),
    .data_out   (bitslip_q)
  );

  async_capture #(
    .payload_t   (cnt_sel_t),
    .RESET_VAL   (cnt_sel_t'({CNT_SEL_W{CFG_RESET_VAL}})),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_cnt_sel (
    .tx_osc_clk (tx_osc_clk),
    .rst        (rst),
    .data_in    (pld_pma_fpll_cnt_sel),
    .unload     (ssr_load),
    .sync_out   (cnt_sel_sync),
    .data_out   (cnt_sel_q)
  );

  async_capture #(
    .payload_t   (phase_shifts_t),
    .RESET_VAL   (phase_shifts_t'({PHASE_SHIFTS_W{CFG_RESET_VAL}})),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_phase_shifts (
    .tx_osc_clk (tx_osc_clk),
    .rst        (rst),
    .data_in    (pld_pma_fpll_num_phase_shifts),
    .unload     (ssr_load),
    .sync_out   (phase_shifts_sync),
    .data_out   (phase_shifts_q)
  );

  // Single bits load straight into their image positions
  async_capture #(.payload_t(logic), .RESET_VAL(CFG_RESET_VAL), .SYNC_STAGES(SYNC_STAGES))
    u_polinv (
      .tx_osc_clk (tx_osc_clk), .rst (rst), .data_in (pld_polinv_tx),
      .unload (ssr_load), .sync_out (), .data_out (ssr_data[POLINV_BIT])
    );

  async_capture #(.payload_t(logic), .RESET_VAL(CFG_RESET_VAL), .SYNC_STAGES(SYNC_STAGES))
    u_latency_adj (
      .tx_osc_clk (tx_osc_clk), .rst (rst), .data_in (pld_tx_fifo_latency_adj_en),
      .unload (ssr_load), .sync_out (), .data_out (ssr_data[LATENCY_ADJ_BIT])
    );

  async_capture #(.payload_t(logic), .RESET_VAL(STATUS_RESET_VAL), .SYNC_STAGES(SYNC_STAGES))
    u_dcd_cal_done (
      .tx_osc_clk (tx_osc_clk), .rst (rst), .data_in (tx_dcd_cal_done),
      .unload (ssr_load), .sync_out (), .data_out (ssr_data[DCD_CAL_DONE_BIT])
    );

  async_capture #(.payload_t(logic), .RESET_VAL(STATUS_RESET_VAL), .SYNC_STAGES(SYNC_STAGES))
    u_dll_lock_req (
      .tx_osc_clk (tx_osc_clk), .rst (rst), .data_in (pld_tx_dll_lock_req),
      .unload (ssr_load), .sync_out (), .data_out (ssr_data[DLL_LOCK_REQ_BIT])
    );

  async_capture #(.payload_t(logic), .RESET_VAL(STATUS_RESET_VAL), .SYNC_STAGES(SYNC_STAGES))
    u_transfer_en (
      .tx_osc_clk (tx_osc_clk), .rst (rst), .data_in (tx_transfer_en),
      .unload (ssr_load), .sync_out (), .data_out (ssr_data[TRANSFER_EN_BIT])
    );

  // Polling bypass picks the live synchronized value
  assign ssr_data[BOUNDARY_SEL_LSB +: BOUNDARY_SEL_W] =
    r_boundary_sel_bypass ? boundary_sel_sync : boundary_sel_q;
  assign ssr_data[BITSLIP_LSB +: BITSLIP_W] =
    r_bitslip_bypass ? bitslip_sync : bitslip_q;
  assign ssr_data[CNT_SEL_LSB +: CNT_SEL_W] =
    r_cnt_sel_bypass ? cnt_sel_sync : cnt_sel_q;
  assign ssr_data[PHASE_SHIFTS_LSB +: PHASE_SHIFTS_W] =
    r_phase_shifts_bypass ? phase_shifts_sync : phase_shifts_q;

  a_bits_hold : assert property (
    @(posedge tx_osc_clk) (!ssr_load && !rst) |=>
      $stable({ssr_data[POLINV_BIT], ssr_data[LATENCY_ADJ_BIT], ssr_data[DCD_CAL_DONE_BIT],
               ssr_data[DLL_LOCK_REQ_BIT], ssr_data[TRANSFER_EN_BIT]})
  ) else $error("slow_sr_capture: single-bit field changed without ssr_load");

endmodule

`default_nettype wire

// ==== hw/tx_async_capture.sv ====
// All inputs except the strobes are asynchronous to tx_osc_clk and must be
// held longer than the synchronizer depth. Depths of 2 or more only.
`timescale 1ns/1ps
`default_nettype none

module tx_async_capture #(
  parameter int FSR_SYNC_STAGES = capture_pkg::FSR_SYNC_STAGES_DEF,
  parameter int SSR_SYNC_STAGES = capture_pkg::SSR_SYNC_STAGES_DEF
) (
  input  wire                              tx_osc_clk,
  input  wire                              rst,

  // Fast image
  input  wire                              pld_txelecidle,
  input  wire                              fsr_load,
  input  wire                              r_txelecidle_rst_val,

  // Slow image fields
  input  wire tx_async_pkg::boundary_sel_t pld_8g_tx_boundary_sel,
  input  wire tx_async_pkg::bitslip_t      pld_10g_tx_bitslip,
  input  wire tx_async_pkg::cnt_sel_t      pld_pma_fpll_cnt_sel,
  input  wire tx_async_pkg::phase_shifts_t pld_pma_fpll_num_phase_shifts,
  input  wire                              pld_polinv_tx,
  input  wire                              pld_tx_fifo_latency_adj_en,
  input  wire                              tx_dcd_cal_done,
  input  wire                              pld_tx_dll_lock_req,
  input  wire                              tx_transfer_en,

  // Slow image control
  input  wire                              ssr_load,
  input  wire                              r_boundary_sel_bypass,
  input  wire                              r_bitslip_bypass,
  input  wire                              r_cnt_sel_bypass,
  input  wire                              r_phase_shifts_bypass,

  output logic                             fsr_data,
  output tx_async_pkg::ssr_data_t          ssr_data
);

  fast_sr_capture #(
    .SYNC_STAGES (FSR_SYNC_STAGES)
  ) u_fast_sr (
    .tx_osc_clk           (tx_osc_clk),
    .rst                  (rst),
    .pld_txelecidle       (pld_txelecidle),
    .fsr_load             (fsr_load),
    .r_txelecidle_rst_val (r_txelecidle_rst_val),
    .fsr_data             (fsr_data)
  );

  slow_sr_capture #(
    .SYNC_STAGES (SSR_SYNC_STAGES)
  ) u_slow_sr (
    .tx_osc_clk                    (tx_osc_clk),
    .rst                           (rst),
    .pld_8g_tx_boundary_sel        (pld_8g_tx_boundary_sel),
    .pld_10g_tx_bitslip            (pld_10g_tx_bitslip),
    .pld_pma_fpll_cnt_sel          (pld_pma_fpll_cnt_sel),
    .pld_pma_fpll_num_phase_shifts (pld_pma_fpll_num_phase_shifts),
    .pld_polinv_tx                 (pld_polinv_tx),
    .pld_tx_fifo_latency_adj_en    (pld_tx_fifo_latency_adj_en),
    .tx_dcd_cal_done               (tx_dcd_cal_done),
    .pld_tx_dll_lock_req           (pld_tx_dll_lock_req),
    .tx_transfer_en                (tx_transfer_en),
    .ssr_load                      (ssr_load),
    .r_boundary_sel_bypass         (r_boundary_sel_bypass),
    .r_bitslip_bypass              (r_bitslip_bypass),
    .r_cnt_sel_bypass              (r_cnt_sel_bypass),
    .r_phase_shifts_bypass         (r_phase_shifts_bypass),
    .ssr_data                      (ssr_data)
  );

endmodule

`default_nettype wire

// ==== sim/tb_tx_async_capture.sv ====
// Runs tx_async_capture with its default synchronizer depths. Expected
// images are built from the field layout in tx_async_pkg.
`timescale 1ns/1ps
`default_nettype none

module tb_tx_async_capture;

  import tx_async_pkg::*;
  import capture_pkg::*;

  localparam int RESET_CYCLES = 3;
  localparam int FSR_STAGES   = FSR_SYNC_STAGES_DEF;
  localparam int SSR_STAGES   = SSR_SYNC_STAGES_DEF;
  localparam int HOLD_CYCLES  = 20;
  localparam int SLOW_LOADS   = 8;

  // Upper bounds on each test's length in cycles
  localparam int RESET_TEST_LEN  = 2 * (RESET_CYCLES + 3);
  localparam int FAST_TEST_LEN   = 2 * (FSR_STAGES + 6);
  localparam int SLOW_TEST_LEN   = SLOW_LOADS * (SSR_STAGES + 4);
  localparam int HOLD_TEST_LEN   = HOLD_CYCLES + 2;
  localparam int BYPASS_TEST_LEN = (SSR_STAGES + 2) + 4 * (SSR_STAGES + 4);
  localparam int TIMEOUT_CYCLES  = 2 * (RESET_TEST_LEN + FAST_TEST_LEN + SLOW_TEST_LEN +
                                        HOLD_TEST_LEN + BYPASS_TEST_LEN);

  logic          tx_osc_clk = 1'b0;
  logic          rst;
  logic          pld_txelecidle;
  logic          fsr_load;
  logic          r_txelecidle_rst_val;
  logic          ssr_load;
  logic          r_boundary_sel_bypass;
  logic          r_bitslip_bypass;
  logic          r_cnt_sel_bypass;
  logic          r_phase_shifts_bypass;
  ssr_data_t     in_image;
  boundary_sel_t pld_8g_tx_boundary_sel;
  bitslip_t      pld_10g_tx_bitslip;
  cnt_sel_t      pld_pma_fpll_cnt_sel;
  phase_shifts_t pld_pma_fpll_num_phase_shifts;
  logic          pld_polinv_tx;
  logic          pld_tx_fifo_latency_adj_en;
  logic          tx_dcd_cal_done;
  logic          pld_tx_dll_lock_req;
  logic          tx_transfer_en;
  logic          fsr_data;
  ssr_data_t     ssr_data;

  ssr_data_t     loaded_image;
  logic          loaded_fsr;
  logic [15:0]   lfsr_state;
  int            fail_count;
  int            fails_before;
  int            tests_passed;
  int            tests_failed;
  int            cycle_count;

  // Field inputs are unpacked from one image word
  assign pld_8g_tx_boundary_sel        = in_image[BOUNDARY_SEL_LSB +: BOUNDARY_SEL_W];
  assign pld_10g_tx_bitslip            = in_image[BITSLIP_LSB +: BITSLIP_W];
  assign pld_pma_fpll_cnt_sel          = in_image[CNT_SEL_LSB +: CNT_SEL_W];
  assign pld_pma_fpll_num_phase_shifts = in_image[PHASE_SHIFTS_LSB +: PHASE_SHIFTS_W];
  assign pld_polinv_tx                 = in_image[POLINV_BIT];
  assign pld_tx_fifo_latency_adj_en    = in_image[LATENCY_ADJ_BIT];
  assign tx_dcd_cal_done               = in_image[DCD_CAL_DONE_BIT];
  assign pld_tx_dll_lock_req           = in_image[DLL_LOCK_REQ_BIT];
  assign tx_transfer_en                = in_image[TRANSFER_EN_BIT];

  tx_async_capture dut (
    .tx_osc_clk                    (tx_osc_clk),
    .rst                           (rst),
    .pld_txelecidle                (pld_txelecidle),
    .fsr_load                      (fsr_load),
    .r_txelecidle_rst_val          (r_txelecidle_rst_val),
    .pld_8g_tx_boundary_sel        (pld_8g_tx_boundary_sel),
    .pld_10g_tx_bitslip            (pld_10g_tx_bitslip),
    .pld_pma_fpll_cnt_sel          (pld_pma_fpll_cnt_sel),
    .pld_pma_fpll_num_phase_shifts (pld_pma_fpll_num_phase_shifts),
    .pld_polinv_tx                 (pld_polinv_tx),
    .pld_tx_fifo_latency_adj_en    (pld_tx_fifo_latency_adj_en),
    .tx_dcd_cal_done               (tx_dcd_cal_done),
    .pld_tx_dll_lock_req           (pld_tx_dll_lock_req),
    .tx_transfer_en                (tx_transfer_en),
    .ssr_load                      (ssr_load),
    .r_boundary_sel_bypass         (r_boundary_sel_bypass),
    .r_bitslip_bypass              (r_bitslip_bypass),
    .r_cnt_sel_bypass              (r_cnt_sel_bypass),
    .r_phase_shifts_bypass         (r_phase_shifts_bypass),
    .fsr_data                      (fsr_data),
    .ssr_data                      (ssr_data)
  );

  always #4 tx_osc_clk = ~tx_osc_clk;

  always @(posedge tx_osc_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Slow image holds while no load and no bypass is active
  a_ssr_holds : assert property (
    @(posedge tx_osc_clk) disable iff (rst)
      (!ssr_load && !r_boundary_sel_bypass && !r_bitslip_bypass &&
       !r_cnt_sel_bypass && !r_phase_shifts_bypass) |=> $stable(ssr_data)
  ) else begin
    $display("ssr_data changed at time %0t without a load or an active bypass", $time);
    fail_count++;
  end

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_image(output ssr_data_t img);
    img = '0;
    for (int i = 0; i < SSR_WIDTH; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      img[i] = lfsr_state[0];
    end
  endtask

  // Config fields come up all ones and status bits low
  function automatic ssr_data_t reset_image();
    ssr_data_t img;
    img = '0;
    img[BOUNDARY_SEL_LSB +: BOUNDARY_SEL_W] = '1;
    img[BITSLIP_LSB +: BITSLIP_W]           = '1;
    img[CNT_SEL_LSB +: CNT_SEL_W]           = '1;
    img[PHASE_SHIFTS_LSB +: PHASE_SHIFTS_W] = '1;
    img[POLINV_BIT]                         = 1'b1;
    img[LATENCY_ADJ_BIT]                    = 1'b1;
    return img;
  endfunction

  function automatic ssr_data_t field_mask(input int idx);
    ssr_data_t mask;
    mask = '0;
    case (idx)
      0:       mask[BOUNDARY_SEL_LSB +: BOUNDARY_SEL_W] = '1;
      1:       mask[BITSLIP_LSB +: BITSLIP_W]           = '1;
      2:       mask[CNT_SEL_LSB +: CNT_SEL_W]           = '1;
      default: mask[PHASE_SHIFTS_LSB +: PHASE_SHIFTS_W] = '1;
    endcase
    return mask;
  endfunction

  task automatic set_bypass(input int idx, input logic val);
    case (idx)
      0:       r_boundary_sel_bypass = val;
      1:       r_bitslip_bypass      = val;
      2:       r_cnt_sel_bypass      = val;
      default: r_phase_shifts_bypass = val;
    endcase
  endtask

  task automatic next_cycle();
    @(negedge tx_osc_clk);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge tx_osc_clk);
  endtask

  // Select level is changed while reset is held
  task automatic apply_reset(input logic sel);
    rst = 1'b1;
    r_txelecidle_rst_val = sel;
    wait_cycles(RESET_CYCLES);
    rst = 1'b0;
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED at time %0t: %s expected %b, got %b",
               $time, name, expected, actual);
      fail_count++;
    end
  endtask

  task automatic check_image(input string name, input ssr_data_t expected,
                             input ssr_data_t actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED at time %0t: %s expected %h, got %h",
               $time, name, expected, actual);
      fail_count++;
    end
  endtask

  task automatic close_test(input string name);
    if (fail_count == fails_before) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: fail with %0d failed checks", name, fail_count - fails_before);
    end
    fails_before = fail_count;
  endtask

  initial begin
    logic      idle_val;
    ssr_data_t mask;
    ssr_data_t expected;

    rst                   = 1'b1;
    pld_txelecidle        = 1'b0;
    fsr_load              = 1'b0;
    r_txelecidle_rst_val  = 1'b0;
    ssr_load              = 1'b0;
    r_boundary_sel_bypass = 1'b0;
    r_bitslip_bypass      = 1'b0;
    r_cnt_sel_bypass      = 1'b0;
    r_phase_shifts_bypass = 1'b0;
    in_image              = '0;
    lfsr_state            = 16'd24;

    apply_reset(1'b0);
    next_cycle();
    check_bit("fsr_data", 1'b0, fsr_data);
    check_image("ssr_data", reset_image(), ssr_data);
    apply_reset(1'b1);
    next_cycle();
    check_bit("fsr_data", 1'b1, fsr_data);
    check_image("ssr_data", reset_image(), ssr_data);
    close_test("reset values");

    // Zero first, so the load is visible against reset level 1
    for (int i = 0; i < 2; i++) begin
      idle_val = i[0];
      pld_txelecidle = idle_val;
      wait_cycles(FSR_STAGES + 1);
      fsr_load = 1'b1;
      next_cycle();
      fsr_load = 1'b0;
      check_bit("fsr_data", idle_val, fsr_data);
      r_txelecidle_rst_val = ~r_txelecidle_rst_val;
      next_cycle();
      check_bit("fsr_data", idle_val, fsr_data);
      r_txelecidle_rst_val = ~r_txelecidle_rst_val;
      next_cycle();
      loaded_fsr = idle_val;
    end
    close_test("fast load");

    for (int n = 0; n < SLOW_LOADS; n++) begin
      random_image(in_image);
      wait_cycles(SSR_STAGES + 1);
      ssr_load = 1'b1;
      next_cycle();
      ssr_load = 1'b0;
      loaded_image = in_image;
      check_image("ssr_data", loaded_image, ssr_data);
    end
    close_test("slow load");

    in_image = ~in_image;
    pld_txelecidle = ~pld_txelecidle;
    for (int n = 0; n < HOLD_CYCLES; n++) begin
      next_cycle();
      check_bit("fsr_data", loaded_fsr, fsr_data);
      check_image("ssr_data", loaded_image, ssr_data);
    end
    close_test("hold without load");

    // Synchronizers settle on the loaded image before polling
    in_image = loaded_image;
    wait_cycles(SSR_STAGES + 1);
    for (int f = 0; f < 4; f++) begin
      mask = field_mask(f);
      set_bypass(f, 1'b1);
      in_image = in_image ^ mask;
      expected = (loaded_image & ~mask) | (in_image & mask);
      wait_cycles(SSR_STAGES + 1);
      check_image("ssr_data", expected, ssr_data);
      set_bypass(f, 1'b0);
      next_cycle();
      check_image("ssr_data", loaded_image, ssr_data);
    end
    close_test("polling bypass");

    $display("Summary: %0d tests passed, %0d tests failed, %0d failed checks",
             tests_passed, tests_failed, fail_count);
    if (tests_failed == 0 && fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hw/tx_async_pkg.sv
hw/capture_pkg.sv
hw/async_capture.sv
hw/fast_sr_capture.sv
hw/slow_sr_capture.sv
hw/tx_async_capture.sv
sim/tb_tx_async_capture.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the tx_async_capture testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_tx_async_capture \
  -o sim_tb_tx_async_capture

status=0
./obj_dir/sim_tb_tx_async_capture > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TESTS FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
